// File: source/posit_mul_params.svh
/*
 * Fixed constants for the 32-bit, es = 2 posit multiplier
 * Word, exponent, significand, product and scale widths
 */
`ifndef POSIT_MUL_PARAMS_SVH
`define POSIT_MUL_PARAMS_SVH

// Posit word width
`define POSIT_NBITS 32

// Exponent field width
`define POSIT_ES 2

// Significand width with the hidden one at the top
`define POSIT_SIG_BITS 28

// Full significand product width
`define POSIT_MBITS 56

// Signed scale of one decoded operand, range -120 to 120
`define POSIT_SCALE_BITS 8

// Signed scale of a product, range -240 to 241
`define POSIT_PSCALE_BITS 9

`endif

// File: source/posit_pkg.sv
/*
 * Shared types of the posit multiplier
 * Posit word, decoded operand and raw product
 */
`include "posit_mul_params.svh"

package posit_pkg;

    // One posit word
    typedef logic [`POSIT_NBITS-1:0] posit_t;

    // Operand after decoding, scale = 4 * regime + exponent
    typedef struct packed {
        logic                           sgn;
        logic [`POSIT_SCALE_BITS-1:0]   scale;  // Two's complement
        logic [`POSIT_SIG_BITS-1:0]     sig;    // Hidden one at the top
        logic                           inf;    // NaR
        logic                           zero;
    } posit_unpacked_t;

    // Product before re-encoding
    // Layout sgn | scale | fraction | inf | zero, 68 bits in all
    typedef struct packed {
        logic                           sgn;
        logic [`POSIT_PSCALE_BITS-1:0]  scale;     // Two's complement
        logic [`POSIT_MBITS-1:0]        fraction;  // Hidden one at bit 55
        logic                           inf;
        logic                           zero;
    } value_product;

endpackage

// File: source/posit_extract.sv
/*
 * Stage 1 of the posit multiplier
 * Decodes both operands into sign, scale, significand and special flags
 */
`timescale 1ns/1ps
`include "posit_mul_params.svh"

module posit_extract (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  posit_pkg::posit_t         a,
    input  posit_pkg::posit_t         b,
    output logic                      x_valid,
    output posit_pkg::posit_unpacked_t x_a,
    output posit_pkg::posit_unpacked_t x_b
);

    // Decode one posit word
    function automatic posit_pkg::posit_unpacked_t decode(input posit_pkg::posit_t p);
        posit_pkg::posit_unpacked_t u;
        logic [`POSIT_NBITS-1:0] mag;
        logic [`POSIT_NBITS-2:0] body;
        logic [`POSIT_NBITS-2:0] rest;
        logic [5:0] run;  // Regime run length, up to 31
        logic run_end;
        logic signed [`POSIT_SCALE_BITS-`POSIT_ES-1:0] k;

        mag = p[`POSIT_NBITS-1] ? -p : p;  // Negative words decode from the magnitude
        body = mag[`POSIT_NBITS-2:0];

        // Leading ones or zeros count of the regime
        run = '0;
        run_end = 1'b0;
        for (int i = `POSIT_NBITS-2; i >= 0; i--) begin
            if (!run_end && body[i] == body[`POSIT_NBITS-2])
                run = run + 6'd1;
            else
                run_end = 1'b1;
        end

        k = body[`POSIT_NBITS-2] ? run - 6'd1 : -run;

        // Drop the regime run and its terminating bit
        rest = body << (run + 6'd1);

        u.sgn = p[`POSIT_NBITS-1];
        u.scale = {k, rest[`POSIT_NBITS-2 -: `POSIT_ES]};  // 4k + e as a concatenation
        u.sig = {1'b1, rest[`POSIT_NBITS-2-`POSIT_ES -: `POSIT_SIG_BITS-1]};
        u.inf = (p == {1'b1, {(`POSIT_NBITS-1){1'b0}}});
        u.zero = (p == '0);
        return u;
    endfunction

    always_ff @(posedge clk) begin
        if (rst)
            x_valid <= 1'b0;
        else
            x_valid <= in_valid;
    end

    // Operand registers follow the strobe only
    always_ff @(posedge clk) begin
        if (in_valid) begin
            x_a <= decode(a);
            x_b <= decode(b);
        end
    end

endmodule

// File: source/posit_multiply.sv
/*
 * Stage 2 of the posit multiplier
 * Sign, scale sum, significand product and special flags
 */
`timescale 1ns/1ps
`include "posit_mul_params.svh"

module posit_multiply (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       x_valid,
    input  posit_pkg::posit_unpacked_t x_a,
    input  posit_pkg::posit_unpacked_t x_b,
    output logic                       p_valid,
    output posit_pkg::value_product    prod
);

    logic [`POSIT_MBITS-1:0]       full;
    logic [`POSIT_MBITS-1:0]       frac_norm;
    logic [`POSIT_PSCALE_BITS-1:0] scale_sum;
    posit_pkg::value_product       next_prod;

    // Two values in [1, 2) give a product in [1, 4)
    assign full = x_a.sig * x_b.sig;

    // Bring the hidden one to bit 55 in both cases
    assign frac_norm = full[`POSIT_MBITS-1] ? full : full << 1;

    // Sign extend both scales, then add the carry out of the significands
    assign scale_sum = {x_a.scale[`POSIT_SCALE_BITS-1], x_a.scale}
                     + {x_b.scale[`POSIT_SCALE_BITS-1], x_b.scale}
                     + {{(`POSIT_PSCALE_BITS-1){1'b0}}, full[`POSIT_MBITS-1]};

    always_comb begin
        next_prod.sgn = x_a.sgn ^ x_b.sgn;
        next_prod.scale = scale_sum;
        next_prod.fraction = frac_norm;
        next_prod.inf = x_a.inf | x_b.inf;  // NaR wins over zero
        next_prod.zero = (x_a.zero | x_b.zero) & ~(x_a.inf | x_b.inf);
    end

    always_ff @(posedge clk) begin
        if (rst)
            p_valid <= 1'b0;
        else
            p_valid <= x_valid;
    end

    always_ff @(posedge clk) begin
        if (x_valid)
            prod <= next_prod;
    end

endmodule

// File: source/posit_normalize_prod.sv
/*
 * Stage 3 of the posit multiplier
 * Regime encoding, round to nearest even, sign and special values
 */
`timescale 1ns/1ps
`include "posit_mul_params.svh"

module posit_normalize_prod (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    p_valid,
    input  posit_pkg::value_product prod,
    output logic                    out_valid,
    output posit_pkg::posit_t       result,
    output logic                    inf,
    output logic                    zero
);

    localparam int W = 2 * `POSIT_NBITS;
    localparam int PAD = W - `POSIT_MBITS - 3;

    logic signed [`POSIT_PSCALE_BITS-1:0] k;  // Regime value
    logic                    neg_regime;
    logic [6:0]              regime_shift;
    logic [`POSIT_ES-1:0]    result_exp;
    logic [W-1:0]            regime_exp_frac;
    logic [W-1:0]            shifted;
    logic [W-1:0]            leftover;
    logic [`POSIT_NBITS-2:0] kept;
    logic                    bafter;
    logic                    sticky;
    logic                    round_up;
    logic [`POSIT_NBITS-1:0] mag_rounded;
    logic [`POSIT_NBITS-2:0] mag_clamped;
    posit_pkg::posit_t       signed_result;
    posit_pkg::posit_t       next_result;

    assign k = $signed(prod.scale) >>> `POSIT_ES;
    assign neg_regime = k[`POSIT_PSCALE_BITS-1];
    assign result_exp = prod.scale[`POSIT_ES-1:0];  // Scale mod 4

    // k >= 0 needs k+1 ones, k < 0 needs -k zeros, so shift by k or ~k
    assign regime_shift = k[6:0] ^ {7{neg_regime}};

    // The top bit fills the run under an arithmetic shift
    assign regime_exp_frac = {~neg_regime, neg_regime, result_exp,
                              prod.fraction[`POSIT_MBITS-2:0], {PAD{1'b0}}};

    assign shifted = $signed(regime_exp_frac) >>> regime_shift;

    // Bits pushed out below bit 0 by the regime shift
    assign leftover = regime_exp_frac << (7'd64 - regime_shift);

    assign kept = shifted[W-1 -: `POSIT_NBITS-1];  // Top 31 bits
    assign bafter = shifted[`POSIT_NBITS];
    assign sticky = |shifted[`POSIT_NBITS-1:0] | |leftover;

    // Above half rounds up, exactly half rounds to the even neighbour
    assign round_up = bafter & (sticky | kept[0]);

    assign mag_rounded = {1'b0, kept} + {{(`POSIT_NBITS-1){1'b0}}, round_up};

    // Saturate at maxpos and never round a nonzero product to zero
    always_comb begin
        if (mag_rounded[`POSIT_NBITS-1])
            mag_clamped = '1;                       // maxpos
        else if (mag_rounded == '0)
            mag_clamped = {{(`POSIT_NBITS-2){1'b0}}, 1'b1};  // minpos
        else
            mag_clamped = mag_rounded[`POSIT_NBITS-2:0];
    end

    assign signed_result = prod.sgn ? -{1'b0, mag_clamped} : {1'b0, mag_clamped};

    always_comb begin
        if (prod.inf)
            next_result = {1'b1, {(`POSIT_NBITS-1){1'b0}}};  // NaR
        else if (prod.zero)
            next_result = '0;
        else
            next_result = signed_result;
    end

    always_ff @(posedge clk) begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= p_valid;
    end

    always_ff @(posedge clk) begin
        if (p_valid) begin
            result <= next_result;
            inf <= prod.inf;
            zero <= prod.zero & ~prod.inf;
        end
    end

endmodule

// File: source/posit_mul.sv
/*
 * Top level of the three-stage posit multiplier
 * Chains extract, multiply and normalize
 */
`timescale 1ns/1ps
`include "posit_mul_params.svh"

module posit_mul (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  posit_pkg::posit_t a,
    input  posit_pkg::posit_t b,
    output logic              out_valid,
    output posit_pkg::posit_t result,
    output logic              inf,
    output logic              zero
);

    logic                       x_valid;
    posit_pkg::posit_unpacked_t x_a;
    posit_pkg::posit_unpacked_t x_b;
    logic                       p_valid;
    posit_pkg::value_product    prod;

    posit_extract u_extract (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .x_valid  (x_valid),
        .x_a      (x_a),
        .x_b      (x_b)
    );

    posit_multiply u_multiply (
        .clk     (clk),
        .rst     (rst),
        .x_valid (x_valid),
        .x_a     (x_a),
        .x_b     (x_b),
        .p_valid (p_valid),
        .prod    (prod)
    );

    // Result leaves three cycles after the operands are sampled
    posit_normalize_prod u_normalize (
        .clk       (clk),
        .rst       (rst),
        .p_valid   (p_valid),
        .prod      (prod),
        .out_valid (out_valid),
        .result    (result),
        .inf       (inf),
        .zero      (zero)
    );

endmodule

// File: verif/posit_mul_props.sv
/*
 * Concurrent assertions for the posit multiplier top level
 * Reset state, three-cycle latency and special results
 */
`timescale 1ns/1ps
`include "posit_mul_params.svh"

module posit_mul_props (
    input logic                    clk,
    input logic                    rst,
    input logic                    in_valid,
    input logic                    out_valid,
    input logic [`POSIT_NBITS-1:0] result,
    input logic                    inf,
    input logic                    zero
);

    localparam logic [`POSIT_NBITS-1:0] NAR = {1'b1, {(`POSIT_NBITS-1){1'b0}}};

    // Valid is cleared on the edge that samples reset
    reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    in_to_out_latency: assert property (@(posedge clk) disable iff (rst)
        $past(in_valid, 3) |-> out_valid)
        else $error("out_valid missing three cycles after in_valid");

    no_spurious_out: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, 3))
        else $error("out_valid without in_valid three cycles earlier");

    inf_means_nar: assert property (@(posedge clk) disable iff (rst)
        out_valid && inf |-> result == NAR)
        else $error("inf flag with a result other than NaR");

    zero_means_zero: assert property (@(posedge clk) disable iff (rst)
        out_valid && zero |-> result == '0)
        else $error("zero flag with a nonzero result");

endmodule

bind posit_mul posit_mul_props u_props (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .inf       (inf),
    .zero      (zero)
);

// File: verif/posit_mul_tb.sv
/*
 * Testbench for the pipelined posit multiplier
 * Directed and random stimulus, expected-value pipeline, error counts
 */
`timescale 1ns/1ps
`include "posit_mul_params.svh"

module posit_mul_tb;

    localparam posit_pkg::posit_t NAR    = 32'h8000_0000;
    localparam posit_pkg::posit_t ONE    = 32'h4000_0000;
    localparam posit_pkg::posit_t MONE   = 32'hC000_0000;
    localparam posit_pkg::posit_t MAXPOS = 32'h7FFF_FFFF;
    localparam posit_pkg::posit_t MINPOS = 32'h0000_0001;

    // Expected response of one item
    typedef struct packed {
        logic              chk;     // Item is checked at the output
        posit_pkg::posit_t result;
        logic              inf;
        logic              zero;
    } expect_t;

    logic              clk;
    logic              rst;
    logic              in_valid;
    posit_pkg::posit_t a;
    posit_pkg::posit_t b;
    logic              out_valid;
    posit_pkg::posit_t result;
    logic              inf;
    logic              zero;

    expect_t    exp_in;          // Travels with a and b
    expect_t    pipe_e [0:2];
    logic [2:0] pipe_v;
    integer     seed = 32'hece3_d4dc;
    int         checks = 0;
    int         value_errors = 0;
    int         timeout_errors = 0;

    posit_mul u_posit_mul (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .inf       (inf),
        .zero      (zero)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Three register stages like the DUT
    always @(posedge clk) begin
        if (rst)
            pipe_v <= '0;
        else
            pipe_v <= {pipe_v[1:0], in_valid};
        pipe_e[0] <= exp_in;
        pipe_e[1] <= pipe_e[0];
        pipe_e[2] <= pipe_e[1];
    end

    // Outputs are compared half a cycle after they change
    always @(negedge clk) begin
        if (!rst) begin
            assert (out_valid === pipe_v[2]) else begin
                value_errors++;
                $display("FAIL t=%0t out_valid expected %b got %b", $time, pipe_v[2], out_valid);
            end
            if (pipe_v[2] && pipe_e[2].chk) begin
                checks++;
                assert (result === pipe_e[2].result) else begin
                    value_errors++;
                    $display("FAIL t=%0t result expected %h got %h",
                             $time, pipe_e[2].result, result);
                end
                assert (inf === pipe_e[2].inf) else begin
                    value_errors++;
                    $display("FAIL t=%0t inf expected %b got %b", $time, pipe_e[2].inf, inf);
                end
                assert (zero === pipe_e[2].zero) else begin
                    value_errors++;
                    $display("FAIL t=%0t zero expected %b got %b", $time, pipe_e[2].zero, zero);
                end
            end
        end
    end

    // Flags follow the value since a nonzero product never rounds to zero
    function automatic expect_t expect_for(input posit_pkg::posit_t r);
        expect_t e;
        e.chk = 1'b1;
        e.result = r;
        e.inf = (r == NAR);
        e.zero = (r == '0);
        return e;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7FFF_FFFF;
        return lo + r % (hi - lo + 1);
    endfunction

    // Posit of 2^s rounded to nearest even on the regime and exponent bit string
    function automatic posit_pkg::posit_t encode_pow2(input int s);
        logic [63:0] bits;
        logic [30:0] kept;
        logic [31:0] mag;
        logic        guard;
        logic        sticky;
        int          k;
        int          pos;
        k = s >>> 2;  // Floor of s / 4
        bits = '0;
        pos = 63;
        if (k >= 0) begin
            for (int n = 0; n <= k; n++) begin
                bits[pos] = 1'b1;
                pos--;
            end
            pos--;  // Terminating zero
        end else begin
            pos = pos + k;
            bits[pos] = 1'b1;
            pos--;
        end
        bits[pos] = s[1];
        bits[pos-1] = s[0];
        kept = bits[63:33];
        guard = bits[32];
        sticky = |bits[31:0];
        mag = {1'b0, kept} + {31'd0, guard & (sticky | kept[0])};
        if (mag[31])
            mag = {1'b0, MAXPOS[30:0]};
        else if (mag == '0)
            mag = MINPOS;
        return mag;
    endfunction

    task automatic issue(input posit_pkg::posit_t x, input posit_pkg::posit_t y,
                         input expect_t e);
        @(posedge clk);
        in_valid <= 1'b1;
        a <= x;
        b <= y;
        exp_in <= e;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic zero_nar_case();
        posit_pkg::posit_t x;
        x = $random(seed);
        if (x == NAR)
            x = ONE;
        issue('0, x, expect_for('0));
        issue(x, '0, expect_for('0));
        issue(NAR, $random(seed), expect_for(NAR));
        issue($random(seed), NAR, expect_for(NAR));
        issue(NAR, '0, expect_for(NAR));  // NaR wins over zero
    endtask

    task automatic identity_case();
        posit_pkg::posit_t x;
        x = $random(seed);
        issue(x, ONE, expect_for(x));
        issue(ONE, x, expect_for(x));
        issue(x, MONE, expect_for(-x));
        issue(MONE, x, expect_for(-x));
    endtask

    // Operands stay where regime and exponent fit exactly
    task automatic power_case();
        int                i;
        int                j;
        int                lo;
        int                hi;
        posit_pkg::posit_t pa;
        posit_pkg::posit_t pr;
        i = rand_range(-112, 111);
        lo = (-120 - i > -112) ? -120 - i : -112;
        hi = (120 - i < 111) ? 120 - i : 111;
        j = rand_range(lo, hi);
        pa = encode_pow2(i);
        pr = encode_pow2(i + j);
        if ($random(seed) & 1) begin
            pa = -pa;
            pr = -pr;
        end
        issue(pa, encode_pow2(j), expect_for(pr));
    endtask

    task automatic saturation_case();
        issue(MAXPOS, MAXPOS, expect_for(MAXPOS));
        issue(MINPOS, MINPOS, expect_for(MINPOS));
        issue(-MAXPOS, MAXPOS, expect_for(-MAXPOS));
        issue(MINPOS, -MINPOS, expect_for(-MINPOS));
        issue(-MAXPOS, -MAXPOS, expect_for(MAXPOS));
    endtask

    // Fills the pipeline with an unchecked item
    task automatic random_case();
        issue($random(seed), $random(seed), '0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle(1);
        while ((pipe_v != '0 || out_valid) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (pipe_v != '0 || out_valid) begin
            timeout_errors++;
            $display("Timeout: the pipeline still held items 20 cycles after the last input");
        end
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        a = '0;
        b = '0;
        exp_in = '0;
        repeat (4) @(posedge clk);
        in_valid <= 1'b1;  // Strobes during reset must not reach the output
        repeat (8) @(posedge clk);
        in_valid <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        repeat (8) zero_nar_case();
        idle(3);
        repeat (20) identity_case();
        idle(2);
        repeat (40) power_case();
        idle(1);
        saturation_case();
        idle(4);

        // Burst of mixed items with short gaps
        for (int n = 0; n < 60; n++) begin
            case (rand_range(0, 4))
                0: zero_nar_case();
                1: identity_case();
                2: power_case();
                3: random_case();
                default: idle(rand_range(1, 2));
            endcase
        end
        drain();

        $display("Checked %0d items, value errors %0d, timeout errors %0d",
                 checks, value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: posit_mul.f
+incdir+source
source/posit_pkg.sv
source/posit_extract.sv
source/posit_multiply.sv
source/posit_normalize_prod.sv
source/posit_mul.sv
verif/posit_mul_props.sv
verif/posit_mul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the posit multiplier testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module posit_mul_tb \
    -f posit_mul.f \
    -Mdir obj_dir \
    -o posit_mul_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/posit_mul_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
